// File: verilog/trainer_pkg.sv
package trainer_pkg;

  //////////////////////////////////////////////////
  // Widths and sizes
  //////////////////////////////////////////////////

  localparam int DATA_W  = 32;  // Every data word
  localparam int SIZE_L  = 4;   // Gate elements per step
  localparam int SIZE_X  = 4;   // Input values per step
  localparam int L_IDX_W = 2;   // Index into l
  localparam int X_IDX_W = 2;   // Index into x
  localparam int T_W     = 8;   // Step count

  //////////////////////////////////////////////////
  // Controller phases
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {
    IDLE,   // Waiting for start
    GATE,   // Taking gate elements
    DRAIN,  // Pipeline emptying
    INPUT,  // Taking x values
    OUT_W,  // Streaming dW
    OUT_B,  // Streaming db
    DONE    // Ready pulse next
  } ctrl_state_e;

  //////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////

  // One gate element from the host
  typedef struct packed {
    logic [DATA_W-1:0] ds;  // State gradient
    logic [DATA_W-1:0] a;   // Activation
    logic [DATA_W-1:0] i;   // Gate value
  } gate_elem_t;

  // One finished delta
  typedef struct packed {
    logic               valid;
    logic [L_IDX_W-1:0] l;
    logic [DATA_W-1:0]  value;
  } delta_t;

  // Readout address into both accumulators
  typedef struct packed {
    logic               en;
    logic [L_IDX_W-1:0] l;
    logic [X_IDX_W-1:0] x;
  } acc_rd_t;

endpackage

// File: verilog/input_gate_delta.sv
`timescale 1ns/1ps

module input_gate_delta (
  input  logic                            CLK,
  input  logic                            RST,
  input  logic                            in_valid,  // Accepted strobe
  input  logic [trainer_pkg::L_IDX_W-1:0] in_l,      // From element counter
  input  trainer_pkg::gate_elem_t         gate,
  output trainer_pkg::delta_t             delta
);
  import trainer_pkg::*;

  // di = ds * a * i * (1 - i)
  // Split over two stages so two elements can be in flight

  //////////////////////////////////////////////////
  // Stage 1
  //////////////////////////////////////////////////

  logic               s1_valid;
  logic [L_IDX_W-1:0] s1_l;
  logic [DATA_W-1:0]  s1_ds_a;    // ds * a
  logic [DATA_W-1:0]  s1_i_term;  // i * (1 - i)

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (in_valid) begin
      s1_l      <= in_l;  // Index rides along
      s1_ds_a   <= gate.ds * gate.a;  // Low DATA_W bits kept
      s1_i_term <= gate.i * (DATA_W'(1) - gate.i);  // Wraps like the rest
    end
  end

  //////////////////////////////////////////////////
  // Stage 2
  //////////////////////////////////////////////////

  logic               s2_valid;
  logic [L_IDX_W-1:0] s2_l;
  logic [DATA_W-1:0]  s2_value;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;  // Two cycles after the strobe
    end
  end

  always_ff @(posedge CLK) begin
    if (s1_valid) begin
      s2_l     <= s1_l;
      s2_value <= s1_ds_a * s1_i_term;  // Final product
    end
  end

  assign delta = '{valid: s2_valid, l: s2_l, value: s2_value};

endmodule

// File: verilog/bias_accumulator.sv
`timescale 1ns/1ps

module bias_accumulator (
  input  logic                           CLK,
  input  logic                           RST,
  input  logic                           clear,  // Start of run
  input  trainer_pkg::delta_t            delta,
  input  trainer_pkg::acc_rd_t           rd,
  output logic [trainer_pkg::DATA_W-1:0] b_out
);
  import trainer_pkg::*;

  // db[l] = sum over t of di(t;l)

  logic [DATA_W-1:0] db [SIZE_L];

  //////////////////////////////////////////////////
  // Accumulate
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int l = 0; l < SIZE_L; l++) begin
        db[l] <= '0;
      end
    end else if (clear) begin
      // Fresh run drops the old sums
      for (int l = 0; l < SIZE_L; l++) begin
        db[l] <= '0;
      end
    end else if (delta.valid) begin
      db[delta.l] <= db[delta.l] + delta.value;  // Wraps mod 2^DATA_W
    end
  end

  //////////////////////////////////////////////////
  // Readout
  //////////////////////////////////////////////////

  // One cycle of latency to b_out
  always_ff @(posedge CLK) begin
    if (rd.en) begin
      b_out <= db[rd.l];
    end
  end

endmodule

// File: verilog/weight_accumulator.sv
`timescale 1ns/1ps

module weight_accumulator (
  input  logic                           CLK,
  input  logic                           RST,
  input  logic                           clear,    // Start of run
  input  trainer_pkg::delta_t            delta,
  input  logic                           x_valid,  // Host keeps to x_enable
  input  logic [trainer_pkg::DATA_W-1:0] x_in,
  input  trainer_pkg::acc_rd_t           rd,
  output logic [trainer_pkg::DATA_W-1:0] w_out
);
  import trainer_pkg::*;

  // dW[l][x] = sum over t of di(t;l) * x(t;x)

  logic [DATA_W-1:0]  dbuf [SIZE_L];          // Deltas of this step
  logic [DATA_W-1:0]  dw   [SIZE_L][SIZE_X];  // Running sums
  logic [X_IDX_W-1:0] col;                    // Column for next x
  logic               col_last;

  assign col_last = (col == X_IDX_W'(SIZE_X - 1));

  //////////////////////////////////////////////////
  // Delta buffer
  //////////////////////////////////////////////////

  // Written by index as deltas leave the pipeline
  // Each step refills all SIZE_L entries before its first x
  always_ff @(posedge CLK) begin
    if (delta.valid) begin
      dbuf[delta.l] <= delta.value;
    end
  end

  //////////////////////////////////////////////////
  // Column update
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      col <= '0;
      for (int l = 0; l < SIZE_L; l++) begin
        for (int x = 0; x < SIZE_X; x++) begin
          dw[l][x] <= '0;
        end
      end
    end else if (clear) begin
      col <= '0;  // Next x is column 0
      for (int l = 0; l < SIZE_L; l++) begin
        for (int x = 0; x < SIZE_X; x++) begin
          dw[l][x] <= '0;
        end
      end
    end else if (x_valid) begin
      // Whole column at once with one multiplier per l
      for (int l = 0; l < SIZE_L; l++) begin
        dw[l][col] <= dw[l][col] + dbuf[l] * x_in;  // Low bits only
      end
      col <= col_last ? '0 : col + 1'b1;  // Wrap every SIZE_X
    end
  end

  //////////////////////////////////////////////////
  // Readout
  //////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (rd.en) begin
      w_out <= dw[rd.l][rd.x];  // Registered with 1 cycle of latency
    end
  end

endmodule

// File: verilog/trainer_controller.sv
`timescale 1ns/1ps

module trainer_controller (
  input  logic                            CLK,
  input  logic                            RST,
  input  logic                            start,
  input  logic [trainer_pkg::T_W-1:0]     size_t,       // Steps in this run
  input  logic                            gate_valid,
  input  logic                            x_valid,
  input  logic                            delta_valid,  // From the pipeline
  output logic [trainer_pkg::L_IDX_W-1:0] gate_l,
  output logic                            gate_accept,
  output logic                            gate_enable,
  output logic                            x_enable,
  output logic                            clear,
  output trainer_pkg::acc_rd_t            rd,
  output logic                            w_valid,
  output logic                            b_valid,
  output logic                            ready
);
  import trainer_pkg::*;

  ctrl_state_e        state;
  logic [L_IDX_W-1:0] elem_cnt;  // Gate elements taken this step
  logic [L_IDX_W-1:0] dlt_cnt;   // Deltas out of the pipeline
  logic [X_IDX_W-1:0] x_cnt;     // x values taken this step
  logic [T_W-1:0]     step_cnt;  // Steps finished
  logic [T_W-1:0]     t_total;   // Latched size_t
  logic [L_IDX_W-1:0] rd_l;      // Readout row
  logic [X_IDX_W-1:0] rd_x;      // Readout column
  logic               x_accept;
  logic               gate_last, dlt_last, x_last, step_last;
  logic               rd_l_last, rd_x_last;

  //////////////////////////////////////////////////
  // Host side levels
  //////////////////////////////////////////////////

  assign gate_enable = (state == GATE);
  assign x_enable    = (state == INPUT);
  assign gate_accept = gate_valid & gate_enable;  // Strobes outside GATE dropped
  assign x_accept    = x_valid & x_enable;
  assign gate_l      = elem_cnt;  // Tags the element with its l
  assign clear       = start & (state == IDLE);  // Single cycle

  assign gate_last = (elem_cnt == L_IDX_W'(SIZE_L - 1));
  assign dlt_last  = (dlt_cnt == L_IDX_W'(SIZE_L - 1));
  assign x_last    = (x_cnt == X_IDX_W'(SIZE_X - 1));
  assign rd_l_last = (rd_l == L_IDX_W'(SIZE_L - 1));
  assign rd_x_last = (rd_x == X_IDX_W'(SIZE_X - 1));
  // size_t of 0 behaves like 1
  assign step_last = (T_W'(step_cnt + 1'b1) >= t_total);

  // Same address feeds both accumulators
  assign rd = '{en: (state == OUT_W) || (state == OUT_B), l: rd_l, x: rd_x};

  //////////////////////////////////////////////////
  // Phase FSM
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= IDLE;
      elem_cnt <= '0;
      dlt_cnt  <= '0;
      x_cnt    <= '0;
      step_cnt <= '0;
      t_total  <= '0;
      rd_l     <= '0;
      rd_x     <= '0;
      w_valid  <= 1'b0;
      b_valid  <= 1'b0;
      ready    <= 1'b0;
    end else begin
      // Flags trail the read enable by the read latency
      w_valid <= (state == OUT_W);
      b_valid <= (state == OUT_B);
      ready   <= (state == DONE);

      // Deltas may land during GATE or DRAIN
      if (delta_valid) begin
        dlt_cnt <= dlt_last ? '0 : dlt_cnt + 1'b1;
      end

      case (state)
        IDLE: begin
          if (start) begin
            state    <= GATE;
            t_total  <= size_t;
            step_cnt <= '0;
            elem_cnt <= '0;
            dlt_cnt  <= '0;
            x_cnt    <= '0;
            rd_l     <= '0;
            rd_x     <= '0;
          end
        end

        GATE: begin
          if (gate_accept) begin
            elem_cnt <= gate_last ? '0 : elem_cnt + 1'b1;
            if (gate_last) begin
              state <= DRAIN;  // gate_enable drops here
            end
          end
        end

        DRAIN: begin
          // Last delta reaches the buffer on this edge too
          if (delta_valid && dlt_last) begin
            state <= INPUT;
          end
        end

        INPUT: begin
          if (x_accept) begin
            x_cnt <= x_last ? '0 : x_cnt + 1'b1;
            if (x_last) begin
              step_cnt <= step_cnt + 1'b1;
              state    <= step_last ? OUT_W : GATE;
            end
          end
        end

        OUT_W: begin  // l outer, x inner
          rd_x <= rd_x_last ? '0 : rd_x + 1'b1;
          if (rd_x_last) begin
            rd_l <= rd_l_last ? '0 : rd_l + 1'b1;
            if (rd_l_last) begin
              state <= OUT_B;  // No gap before db
            end
          end
        end

        OUT_B: begin
          rd_l <= rd_l_last ? '0 : rd_l + 1'b1;
          if (rd_l_last) begin
            state <= DONE;
          end
        end

        DONE: begin
          state <= IDLE;  // ready rises on this edge
        end

        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

// File: verilog/model_input_trainer.sv
`timescale 1ns/1ps

module model_input_trainer (
  input  logic                           CLK,
  input  logic                           RST,

  // Run control
  input  logic                           start,
  input  logic [trainer_pkg::T_W-1:0]    size_t,
  output logic                           ready,

  // Gate elements
  input  logic                           gate_valid,
  input  trainer_pkg::gate_elem_t        gate,
  output logic                           gate_enable,

  // Input vector
  input  logic                           x_valid,
  input  logic [trainer_pkg::DATA_W-1:0] x_in,
  output logic                           x_enable,

  // Gradient streams
  output logic [trainer_pkg::DATA_W-1:0] w_out,
  output logic                           w_valid,
  output logic [trainer_pkg::DATA_W-1:0] b_out,
  output logic                           b_valid
);
  import trainer_pkg::*;

  logic               gate_accept;  // Qualified strobe into the pipeline
  logic [L_IDX_W-1:0] gate_l;
  logic               clear;
  delta_t             delta;
  acc_rd_t            rd;

  //////////////////////////////////////////////////
  // Sequencing
  //////////////////////////////////////////////////

  trainer_controller u_ctrl (
    .CLK        (CLK),
    .RST        (RST),
    .start      (start),
    .size_t     (size_t),
    .gate_valid (gate_valid),
    .x_valid    (x_valid),
    .delta_valid(delta.valid),
    .gate_l     (gate_l),
    .gate_accept(gate_accept),
    .gate_enable(gate_enable),
    .x_enable   (x_enable),
    .clear      (clear),
    .rd         (rd),
    .w_valid    (w_valid),
    .b_valid    (b_valid),
    .ready      (ready)
  );

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  input_gate_delta u_delta (
    .CLK     (CLK),
    .RST     (RST),
    .in_valid(gate_accept),
    .in_l    (gate_l),
    .gate    (gate),
    .delta   (delta)
  );

  bias_accumulator u_bias (
    .CLK  (CLK),
    .RST  (RST),
    .clear(clear),
    .delta(delta),
    .rd   (rd),
    .b_out(b_out)
  );

  // x goes straight in, the controller only counts it
  weight_accumulator u_weight (
    .CLK    (CLK),
    .RST    (RST),
    .clear  (clear),
    .delta  (delta),
    .x_valid(x_valid),
    .x_in   (x_in),
    .rd     (rd),
    .w_out  (w_out)
  );

endmodule

// File: testbench/model_input_trainer_sva.sv
`timescale 1ns/1ps

module model_input_trainer_sva (
  input logic CLK,
  input logic RST,
  input logic gate_enable,
  input logic x_enable,
  input logic w_valid,
  input logic b_valid,
  input logic ready
);

  //////////////////////////////////////////////////
  // Output protocol
  //////////////////////////////////////////////////

  // Host sees one phase at a time
  enables_apart: assert property (@(posedge CLK) disable iff (RST)
    !(gate_enable && x_enable))
    else $error("gate_enable and x_enable high in the same cycle");

  ready_single: assert property (@(posedge CLK) disable iff (RST)
    ready |=> !ready)  // Pulse, not a level
    else $error("ready held for more than one cycle");

  streams_apart: assert property (@(posedge CLK) disable iff (RST)
    !(w_valid && b_valid))  // db only after dW
    else $error("w_valid and b_valid high in the same cycle");

  // End of db stream marks the end of the run
  ready_after_b: assert property (@(posedge CLK) disable iff (RST)
    $fell(b_valid) |-> ready)
    else $error("ready missing one cycle after b_valid fell");

  ready_needs_b: assert property (@(posedge CLK) disable iff (RST)
    ready |-> $past(b_valid))
    else $error("ready without a db word in the cycle before");

endmodule

// File: testbench/tb_model_input_trainer.sv
`timescale 1ns/1ps

module tb_model_input_trainer;
  import trainer_pkg::*;

  localparam int MAX_T   = 8;    // Deepest run in this bench
  localparam int TIMEOUT = 200;  // Cycles allowed per wait

  logic              CLK;
  logic              RST;
  logic              start;
  logic [T_W-1:0]    size_t;
  logic              gate_valid;
  gate_elem_t        gate;
  logic              gate_enable;
  logic              x_valid;
  logic [DATA_W-1:0] x_in;
  logic              x_enable;
  logic [DATA_W-1:0] w_out;
  logic              w_valid;
  logic [DATA_W-1:0] b_out;
  logic              b_valid;
  logic              ready;

  gate_elem_t        st_gate [MAX_T][SIZE_L];  // Stimulus of the run
  logic [DATA_W-1:0] st_x    [MAX_T][SIZE_X];
  logic [DATA_W-1:0] exp_w   [SIZE_L][SIZE_X];  // Reference dW
  logic [DATA_W-1:0] exp_b   [SIZE_L];          // Reference db
  logic [DATA_W-1:0] lcg_state;
  int                w_cnt;      // dW words seen this run
  int                b_cnt;      // db words seen this run
  int                ready_cnt;  // ready pulses this run

  model_input_trainer DUT (
    .CLK        (CLK),
    .RST        (RST),
    .start      (start),
    .size_t     (size_t),
    .ready      (ready),
    .gate_valid (gate_valid),
    .gate       (gate),
    .gate_enable(gate_enable),
    .x_valid    (x_valid),
    .x_in       (x_in),
    .x_enable   (x_enable),
    .w_out      (w_out),
    .w_valid    (w_valid),
    .b_out      (b_out),
    .b_valid    (b_valid)
  );

  bind model_input_trainer model_input_trainer_sva u_sva (
    .CLK        (CLK),
    .RST        (RST),
    .gate_enable(gate_enable),
    .x_enable   (x_enable),
    .w_valid    (w_valid),
    .b_valid    (b_valid),
    .ready      (ready)
  );

  initial CLK = 1'b0;
  always #20 CLK = ~CLK;  // 40 ns period

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [DATA_W-1:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;  // Numerical Recipes LCG
    return lcg_state;
  endfunction

  // Expected sums straight from the gradient rules, all mod 2^DATA_W
  function automatic void compute_expected(input int steps);
    logic [DATA_W-1:0] di;
    for (int l = 0; l < SIZE_L; l++) begin
      exp_b[l] = '0;
      for (int x = 0; x < SIZE_X; x++) exp_w[l][x] = '0;
    end
    for (int t = 0; t < steps; t++) begin
      for (int l = 0; l < SIZE_L; l++) begin
        di = st_gate[t][l].ds * st_gate[t][l].a;
        di = di * st_gate[t][l].i * (32'd1 - st_gate[t][l].i);  // ds a i (1 - i)
        exp_b[l] = exp_b[l] + di;
        for (int x = 0; x < SIZE_X; x++) begin
          exp_w[l][x] = exp_w[l][x] + di * st_x[t][x];
        end
      end
    end
  endfunction

  task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] want);
    assert (got === want) else begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, want);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond) else begin
      $display("%s", what);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  // sel 0 gate_enable, 1 x_enable, else ready
  task automatic wait_high(input int sel, input string name);
    bit seen;
    int n;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < TIMEOUT) begin
      @(negedge CLK);  // Levels settled here
      case (sel)
        0:       seen = gate_enable;
        1:       seen = x_enable;
        default: seen = ready;
      endcase
      n++;
    end
    check_true(seen, $sformatf("Timed out waiting for %s to rise", name));
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic send_step(input int t, input bit gaps);
    int gap;
    wait_high(0, "gate_enable");
    for (int l = 0; l < SIZE_L; l++) begin
      gap = gaps ? int'((next_random() >> 16) % 32'd3) : 0;
      repeat (gap) begin
        @(posedge CLK);
        gate_valid <= 1'b0;  // Idle cycle
      end
      @(posedge CLK);
      gate_valid <= 1'b1;
      gate       <= st_gate[t][l];
    end
    @(posedge CLK);
    gate_valid <= 1'b0;
    wait_high(1, "x_enable");
    for (int x = 0; x < SIZE_X; x++) begin
      gap = gaps ? int'((next_random() >> 16) % 32'd3) : 0;
      repeat (gap) begin
        @(posedge CLK);
        x_valid <= 1'b0;
      end
      @(posedge CLK);
      x_valid <= 1'b1;
      x_in    <= st_x[t][x];
    end
    @(posedge CLK);
    x_valid <= 1'b0;
  endtask

  task automatic run_trainer(input int steps, input bit gaps);
    w_cnt     = 0;
    b_cnt     = 0;
    ready_cnt = 0;
    compute_expected(steps);
    @(posedge CLK);
    start  <= 1'b1;
    size_t <= T_W'(steps);
    @(posedge CLK);
    start  <= 1'b0;
    for (int t = 0; t < steps; t++) send_step(t, gaps);
    wait_high(2, "ready");
    repeat (3) @(negedge CLK);  // Room for a stray second pulse
    check_value("ready pulse count", ready_cnt, 32'd1);
  endtask

  //////////////////////////////////////////////////
  // Compare
  //////////////////////////////////////////////////

  always @(negedge CLK) begin
    if (!RST) begin
      if (w_valid) begin  // l outer, x inner
        check_true(w_cnt < SIZE_L * SIZE_X, "w_valid stayed high past the last dW word");
        check_value($sformatf("w_out[%0d][%0d]", w_cnt / SIZE_X, w_cnt % SIZE_X),
                    w_out, exp_w[w_cnt / SIZE_X][w_cnt % SIZE_X]);
        w_cnt++;
      end
      if (b_valid) begin
        check_true(w_cnt == SIZE_L * SIZE_X, "b_valid rose before the dW stream ended");
        check_true(b_cnt < SIZE_L, "b_valid stayed high past the last db word");
        check_value($sformatf("b_out[%0d]", b_cnt), b_out, exp_b[b_cnt]);
        b_cnt++;
      end
      if (ready) begin
        check_value("w_valid count", w_cnt, SIZE_L * SIZE_X);
        check_value("b_valid count", b_cnt, SIZE_L);
        ready_cnt++;
      end
    end
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    lcg_state  = 32'd86;
    RST        = 1'b1;
    start      = 1'b0;
    size_t     = '0;
    gate_valid = 1'b0;
    gate       = '0;
    x_valid    = 1'b0;
    x_in       = '0;
    w_cnt      = 0;
    b_cnt      = 0;
    ready_cnt  = 0;
    repeat (8) @(posedge CLK);
    RST <= 1'b0;

    // Quiet outputs until the first start
    repeat (4) begin
      @(negedge CLK);
      check_value("ready", 32'(ready), 32'd0);
      check_value("w_valid", 32'(w_valid), 32'd0);
      check_value("b_valid", 32'(b_valid), 32'd0);
      check_value("gate_enable", 32'(gate_enable), 32'd0);
      check_value("x_enable", 32'(x_enable), 32'd0);
    end

    // One step, small values
    for (int l = 0; l < SIZE_L; l++) begin
      st_gate[0][l] = '{ds: DATA_W'(l + 1), a: 32'd2, i: DATA_W'(l + 2)};
    end
    for (int x = 0; x < SIZE_X; x++) st_x[0][x] = DATA_W'(x + 1);
    run_trainer(1, 1'b0);

    // Five steps of full-width data, strobes back to back
    for (int t = 0; t < 5; t++) begin
      for (int l = 0; l < SIZE_L; l++) begin
        st_gate[t][l] = '{ds: next_random(), a: next_random(), i: next_random()};
      end
      for (int x = 0; x < SIZE_X; x++) st_x[t][x] = next_random();
    end
    run_trainer(5, 1'b0);

    // Same data with idle gaps, sums must not carry over
    run_trainer(5, 1'b1);

    $display("All checks passed");
    $finish;
  end

endmodule

// File: list.f
verilog/trainer_pkg.sv
verilog/input_gate_delta.sv
verilog/bias_accumulator.sv
verilog/weight_accumulator.sv
verilog/trainer_controller.sv
verilog/model_input_trainer.sv
testbench/model_input_trainer_sva.sv
testbench/tb_model_input_trainer.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, exit status follows the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f list.f \
  --top-module tb_model_input_trainer \
  -Mdir obj_dir -o sim_tb \
  && ./obj_dir/sim_tb \
  || { echo "Simulation did not pass"; exit 1; }
